//--- kd_tree_search.f
+incdir+verif
logic/kd_tree_pkg.sv
logic/node_loader.sv
logic/internal_node.sv
logic/tree_pipeline.sv
logic/leaf_encoder.sv
logic/kd_tree_search.sv
verif/kd_tree_search_tb.sv

//--- verif/kd_tree_ref.svh
// ====================================================================
// behavioral tree model, included inside the testbench module after
// the package import; nodes must be stored in breadth-first order
// ====================================================================
`ifndef KD_TREE_REF_SVH
`define KD_TREE_REF_SVH

// split per node, breadth-first address
dim_t       model_dim    [NUM_NODES];
coord_t     model_median [NUM_NODES];
// next node the model expects to be written
node_addr_t model_wr_addr;

// state of a freshly reset tree
function automatic void clear_model();
  for (int n = 0; n < NUM_NODES; n++) begin
    model_dim[n]    = INVALID_DIM;
    model_median[n] = '0;
  end
  model_wr_addr = '0;
endfunction

// one node write, address wraps after the last node
function automatic void store_node(input node_word_t word);
  // dimension in bits 2..0, median in the high 11 bits
  model_dim[model_wr_addr]    = word[2:0];
  model_median[model_wr_addr] = word[COORD_WIDTH +: COORD_WIDTH];
  if (model_wr_addr == node_addr_t'(NUM_NODES - 1)) begin
    model_wr_addr = '0;
  end else begin
    model_wr_addr = model_wr_addr + 1'b1;
  end
endfunction

// coordinate k of a patch, signed
function automatic coord_t coord_of(input patch_t p, input int k);
  return coord_t'(p[k*COORD_WIDTH +: COORD_WIDTH]);
endfunction

// expected leaf: less than median goes left, else right
function automatic leaf_idx_t walk_tree(input patch_t p);
  int     pos;
  int     addr;
  coord_t c;
  pos = 0;
  for (int lvl = 0; lvl < TREE_DEPTH; lvl++) begin
    addr = (1 << lvl) + pos - 1;
    // unwritten dimension compares as zero
    c = (model_dim[addr] < NUM_DIMS) ? coord_of(p, model_dim[addr]) : coord_t'(0);
    if (c < model_median[addr]) begin
      pos = 2 * pos;
    end else begin
      pos = 2 * pos + 1;
    end
  end
  return leaf_idx_t'(pos);
endfunction

`endif

//--- verif/kd_tree_search_tb.sv
// ====================================================================
// random trees loaded twice, patch table applied back to back;
// results are matched in issue order against the behavioral model
// ====================================================================
`default_nettype none

module kd_tree_search_tb
  import kd_tree_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  `include "kd_tree_ref.svh"

  localparam int TABLE_LEN     = 24;
  localparam int RESET_CYCLES  = 8;
  // drive edge to the edge where the monitor sees receiver_en
  localparam int LATENCY_EDGES = 9;
  localparam int DRAIN_TIMEOUT = 40;

  // DUT signals
  logic       clk;
  logic       rst_n;
  logic       fsm_enable;
  logic       sender_enable;
  node_word_t sender_data;
  logic       patch_en;
  patch_t     patch_in;
  leaf_idx_t  leaf_index;
  logic       receiver_en;
  logic       tree_loaded;

  integer      seed = 93;
  int unsigned cycle = 0;
  int unsigned pulse_count;
  int unsigned issued_count;

  // results in flight, oldest first
  leaf_idx_t   exp_leaf_q  [$];
  int unsigned exp_cycle_q [$];

  // patch table: enable, tie flag, stimulus, expected leaf
  logic      tbl_en    [TABLE_LEN];
  logic      tbl_tie   [TABLE_LEN];
  patch_t    tbl_patch [TABLE_LEN];
  leaf_idx_t tbl_exp   [TABLE_LEN];

  kd_tree_search DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .fsm_enable    (fsm_enable),
    .sender_enable (sender_enable),
    .sender_data   (sender_data),
    .patch_en      (patch_en),
    .patch_in      (patch_in),
    .leaf_index    (leaf_index),
    .receiver_en   (receiver_en),
    .tree_loaded   (tree_loaded)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // edge counter for arrival checks
  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // outputs seen here were registered one edge earlier
  always @(posedge clk) begin
    if (rst_n && receiver_en) begin
      if (exp_leaf_q.size() == 0) begin
        report_failure("receiver_en pulsed with no patch in flight");
      end else begin
        check_value("receiver_en arrival cycle", cycle, exp_cycle_q.pop_front());
        check_value("leaf_index", leaf_index, exp_leaf_q.pop_front());
        pulse_count = pulse_count + 1;
      end
    end else if (rst_n && exp_cycle_q.size() != 0 && exp_cycle_q[0] == cycle) begin
      report_failure("receiver_en missing for an issued patch");
    end
  end

  // dimension 0..4, median within +-400 so both branches occur
  function automatic node_word_t random_node_word();
    int d;
    int m;
    d = $unsigned($random(seed)) % NUM_DIMS;
    m = $random(seed) % 401;
    return {coord_t'(m), 8'h00, dim_t'(d)};
  endfunction

  function automatic patch_t uniform_patch(input int v);
    patch_t p;
    for (int k = 0; k < NUM_DIMS; k++) begin
      p[k*COORD_WIDTH +: COORD_WIDTH] = coord_t'(v);
    end
    return p;
  endfunction

  function automatic patch_t with_coord(input patch_t p, input int k, input int v);
    p[k*COORD_WIDTH +: COORD_WIDTH] = coord_t'(v);
    return p;
  endfunction

  function automatic patch_t random_patch();
    patch_t p;
    for (int k = 0; k < NUM_DIMS; k++) begin
      p[k*COORD_WIDTH +: COORD_WIDTH] = coord_t'($random(seed) % 600);
    end
    return p;
  endfunction

  // put the median into each first-seen dimension along the path
  function automatic patch_t force_ties(input patch_t base);
    patch_t              p;
    logic [NUM_DIMS-1:0] used;
    int                  pos;
    int                  addr;
    dim_t                d;
    p    = base;
    used = '0;
    pos  = 0;
    for (int lvl = 0; lvl < TREE_DEPTH; lvl++) begin
      addr = (1 << lvl) + pos - 1;
      d    = model_dim[addr];
      if (!used[d]) begin
        p[d*COORD_WIDTH +: COORD_WIDTH] = model_median[addr];
        used[d] = 1'b1;
      end
      // follow whatever path the patch takes now
      pos = (coord_of(p, d) < model_median[addr]) ? 2 * pos : 2 * pos + 1;
    end
    return p;
  endfunction

  task automatic fill_table();
    for (int e = 0; e < TABLE_LEN; e++) begin
      tbl_patch[e] = random_patch();
      tbl_en[e]    = (e % 5 != 4);
      tbl_tie[e]   = (e % 8 == 5);
    end
    // corners and signed values
    tbl_patch[0] = uniform_patch(0);
    tbl_patch[1] = uniform_patch(-1);
    tbl_patch[2] = uniform_patch(1023);
    tbl_patch[3] = uniform_patch(-1024);
    tbl_patch[6] = with_coord(uniform_patch(0), 0, -5);
    tbl_patch[6] = with_coord(tbl_patch[6], 1, 300);
    tbl_patch[6] = with_coord(tbl_patch[6], 2, -700);
    tbl_patch[6] = with_coord(tbl_patch[6], 4, 42);
  endtask

  // ties depend on the tree, so rebuild after every load
  task automatic prepare_table();
    for (int e = 0; e < TABLE_LEN; e++) begin
      if (tbl_tie[e]) begin
        tbl_patch[e] = force_ties(tbl_patch[e]);
      end
      tbl_exp[e] = walk_tree(tbl_patch[e]);
    end
  endtask

  // every write is followed by one blocked strobe with junk data
  task automatic load_tree(input logic loaded_before);
    node_word_t word;
    for (int n = 0; n < NUM_NODES; n++) begin
      @(posedge clk);
      check_value("tree_loaded", tree_loaded, loaded_before);
      word = random_node_word();
      fsm_enable    <= 1'b1;
      sender_enable <= 1'b1;
      sender_data   <= word;
      store_node(word);
      @(posedge clk);
      sender_data   <= node_word_t'($random(seed));
      fsm_enable    <= (n % 3 == 1);
      sender_enable <= (n % 3 == 0);
    end
    @(posedge clk);
    fsm_enable    <= 1'b0;
    sender_enable <= 1'b0;
    check_value("tree_loaded", tree_loaded, 1'b1);
  endtask

  // one entry per cycle, disabled entries still drive data
  task automatic apply_table();
    for (int e = 0; e < TABLE_LEN; e++) begin
      @(posedge clk);
      patch_en <= tbl_en[e];
      patch_in <= tbl_patch[e];
      if (tbl_en[e]) begin
        exp_leaf_q.push_back(tbl_exp[e]);
        exp_cycle_q.push_back(cycle + LATENCY_EDGES);
        issued_count = issued_count + 1;
      end
    end
    @(posedge clk);
    patch_en <= 1'b0;
  endtask

  task automatic wait_for_results();
    int waited;
    waited = 0;
    while (exp_leaf_q.size() != 0) begin
      @(negedge clk);
      waited = waited + 1;
      if (waited > DRAIN_TIMEOUT) begin
        report_failure("timeout waiting for outstanding search results");
      end
    end
    check_value("receiver_en pulse count", pulse_count, issued_count);
  endtask

  initial begin
    rst_n         = 1'b0;
    fsm_enable    = 1'b0;
    sender_enable = 1'b0;
    sender_data   = '0;
    patch_en      = 1'b0;
    patch_in      = '0;
    pulse_count   = 0;
    issued_count  = 0;
    clear_model();
    fill_table();

    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("receiver_en", receiver_en, 1'b0);
    check_value("tree_loaded", tree_loaded, 1'b0);
    check_value("leaf_index", leaf_index, 6'd0);
    // quiet output with no patch
    repeat (10) begin
      @(negedge clk);
      check_value("receiver_en", receiver_en, 1'b0);
    end

    load_tree(1'b0);
    prepare_table();
    apply_table();
    wait_for_results();

    // counter has wrapped, full reload with new words
    load_tree(1'b1);
    prepare_table();
    apply_table();
    wait_for_results();

    // idle tail, a stray pulse here trips the monitor
    repeat (10) @(negedge clk);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule : kd_tree_search_tb

`default_nettype wire

//--- logic/kd_tree_search.sv
// ====================================================================
// load all 63 nodes before searching; a patch taken at edge N gives
// receiver_en and leaf_index for one cycle after edge N+7
// ====================================================================
`default_nettype none

module kd_tree_search
  import kd_tree_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       fsm_enable,
  input  wire logic       sender_enable,
  input  wire node_word_t sender_data,
  input  wire logic       patch_en,
  input  wire patch_t     patch_in,
  output leaf_idx_t       leaf_index,
  output logic            receiver_en,
  output logic            tree_loaded
);

  // loader to tree
  logic [NUM_NODES-1:0]  node_wen;
  node_word_t            node_wdata;

  // tree to encoder
  logic [NUM_LEAVES-1:0] leaf_valids;

  // write side, breadth-first node fill
  node_loader u_loader (
    .clk           (clk),
    .rst_n         (rst_n),
    .fsm_enable    (fsm_enable),
    .sender_enable (sender_enable),
    .sender_data   (sender_data),
    .node_wen      (node_wen),
    .node_wdata    (node_wdata),
    .tree_loaded   (tree_loaded)
  );

  // search side, six pipelined levels
  tree_pipeline u_tree (
    .clk         (clk),
    .rst_n       (rst_n),
    .patch_en    (patch_en),
    .patch_in    (patch_in),
    .node_wen    (node_wen),
    .node_wdata  (node_wdata),
    .leaf_valids (leaf_valids)
  );

  // result register
  leaf_encoder u_encoder (
    .clk         (clk),
    .rst_n       (rst_n),
    .leaf_valids (leaf_valids),
    .leaf_index  (leaf_index),
    .receiver_en (receiver_en)
  );

endmodule : kd_tree_search

`default_nettype wire

//--- logic/leaf_encoder.sv
// ====================================================================
// result is a one-cycle strobe with no back-pressure; leaf_index
// holds its last value between results
// ====================================================================
`default_nettype none

module leaf_encoder
  import kd_tree_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic [NUM_LEAVES-1:0] leaf_valids,
  output leaf_idx_t                  leaf_index,
  output logic                       receiver_en
);

  // position of the set bit
  leaf_idx_t enc_idx;
  logic      any_valid;

  // priority loop, one-hot input so order is irrelevant
  always_comb begin
    enc_idx = '0;
    for (int i = 0; i < NUM_LEAVES; i++) begin
      if (leaf_valids[i]) begin
        enc_idx = leaf_idx_t'(i);
      end
    end
  end

  assign any_valid = |leaf_valids;

  // output register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      leaf_index  <= '0;
      receiver_en <= 1'b0;
    end else begin
      receiver_en <= any_valid;
      // keep last result when idle
      if (any_valid) begin
        leaf_index <= enc_idx;
      end
    end
  end

  // one patch reaches one leaf
  a_leaf_onehot : assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(leaf_valids)
  );

endmodule : leaf_encoder

`default_nettype wire

//--- logic/tree_pipeline.sv
// ====================================================================
// one tree level per cycle, leaf valids six edges after the input
// register; node contents are read as the patch passes each level
// ====================================================================
`default_nettype none

module tree_pipeline
  import kd_tree_pkg::*;
(
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 patch_en,
  input  wire patch_t               patch_in,
  input  wire logic [NUM_NODES-1:0] node_wen,
  input  wire node_word_t           node_wdata,
  output logic [NUM_LEAVES-1:0]     leaf_valids
);

  // valids use heap numbering: root is 1, children of h are 2h and
  // 2h+1, leaves sit at 64..127 so leaf index is h - 64
  logic [2*NUM_LEAVES-1:1] valid_q;

  // node outputs, indexed by the child they feed
  wire  [2*NUM_LEAVES-1:2] child_valid;

  // patch copy per level, level i loaded i edges after the input
  patch_t lvl_patch [TREE_DEPTH];

  // input stage and per-level valid registers
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      // root valid
      valid_q[1] <= patch_en;
      // every node output moves one level down
      valid_q[2*NUM_LEAVES-1:2] <= child_valid;
    end
  end

  // patch shift, no reset needed on payload
  always_ff @(posedge clk) begin
    if (patch_en) begin
      lvl_patch[0] <= patch_in;
    end
    for (int k = 1; k < TREE_DEPTH; k++) begin
      lvl_patch[k] <= lvl_patch[k-1];
    end
  end

  // node array, level i holds 2^i nodes
  for (genvar i = 0; i < TREE_DEPTH; i++) begin : g_level
    for (genvar j = 0; j < 2 ** i; j++) begin : g_node
      // heap number of this node, write address is one less
      localparam int HEAP = (2 ** i) + j;

      internal_node u_node (
        .clk         (clk),
        .rst_n       (rst_n),
        .wen         (node_wen[HEAP-1]),
        .valid       (valid_q[HEAP]),
        .wdata       (node_wdata),
        .patch_in    (lvl_patch[i]),
        .valid_left  (child_valid[2*HEAP]),
        .valid_right (child_valid[2*HEAP+1])
      );
    end
  end

  // last register stage is the leaf row
  assign leaf_valids = valid_q[NUM_LEAVES +: NUM_LEAVES];

  // each patch occupies at most one slot per level, also
  // checks that routing never duplicates a path
  for (genvar i = 1; i <= TREE_DEPTH; i++) begin : g_chk
    a_level_onehot : assert property (
      @(posedge clk) disable iff (!rst_n)
      $onehot0(valid_q[2**i +: 2**i])
    );
  end

endmodule : tree_pipeline

`default_nettype wire

//--- logic/internal_node.sv
// ====================================================================
// node word: dimension in bits 2..0, median in bits 21..11; a
// dimension of 5 or 6 is illegal, 7 means not yet written
// ====================================================================
`default_nettype none

module internal_node
  import kd_tree_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       wen,
  input  wire logic       valid,
  input  wire node_word_t wdata,
  input  wire patch_t     patch_in,
  output logic            valid_left,
  output logic            valid_right
);

  // stored split
  dim_t   dim_q;
  coord_t median_q;

  // coordinate picked by the stored dimension
  coord_t sel_coord;
  logic   go_left;

  // split storage, written once per load pass
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dim_q    <= INVALID_DIM;
      median_q <= '0;
    end else if (wen) begin
      // only the low bits of the dimension field matter
      dim_q    <= wdata[DIM_WIDTH-1:0];
      median_q <= wdata[2*COORD_WIDTH-1:COORD_WIDTH];
    end
  end

  // coordinate select
  always_comb begin
    case (dim_q)
      3'd0:    sel_coord = patch_in[0*COORD_WIDTH +: COORD_WIDTH];
      3'd1:    sel_coord = patch_in[1*COORD_WIDTH +: COORD_WIDTH];
      3'd2:    sel_coord = patch_in[2*COORD_WIDTH +: COORD_WIDTH];
      3'd3:    sel_coord = patch_in[3*COORD_WIDTH +: COORD_WIDTH];
      3'd4:    sel_coord = patch_in[4*COORD_WIDTH +: COORD_WIDTH];
      // unwritten node compares zero against the median
      default: sel_coord = '0;
    endcase
  end

  // signed compare, equal goes right
  assign go_left = (sel_coord < median_q);

  // valid leaves on exactly one side
  assign valid_left  = valid && go_left;
  assign valid_right = valid && !go_left;

  // host must only load real dimensions
  a_dim_legal : assert property (
    @(posedge clk) disable iff (!rst_n)
    (dim_q < dim_t'(NUM_DIMS)) || (dim_q == INVALID_DIM)
  );

endmodule : internal_node

`default_nettype wire

//--- logic/node_loader.sv
// ====================================================================
// nodes are written in breadth-first order only, one per strobe;
// the address wraps after the last node, so a full reload is possible
// ====================================================================
`default_nettype none

module node_loader
  import kd_tree_pkg::*;
(
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 fsm_enable,
  input  wire logic                 sender_enable,
  input  wire node_word_t           sender_data,
  output logic [NUM_NODES-1:0]      node_wen,
  output node_word_t                node_wdata,
  output logic                      tree_loaded
);

  // write strobe from host
  logic       wen;
  // next node to be written
  node_addr_t wr_addr;

  assign wen = fsm_enable && sender_enable;

  // write data goes to every node, enable picks one
  assign node_wdata = sender_data;

  // address counter, wraps 62 -> 0
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_addr <= '0;
    end else if (wen) begin
      if (wr_addr == LAST_ADDR) begin
        wr_addr <= '0;
      end else begin
        wr_addr <= wr_addr + 1'b1;
      end
    end
  end

  // sticky once the last node is written
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tree_loaded <= 1'b0;
    end else if (wen && (wr_addr == LAST_ADDR)) begin
      tree_loaded <= 1'b1;
    end
  end

  // one-hot decode of the address, gated by strobe
  always_comb begin
    node_wen = '0;
    for (int q = 0; q < NUM_NODES; q++) begin
      if (wen && (wr_addr == node_addr_t'(q))) begin
        node_wen[q] = 1'b1;
      end
    end
  end

  // at most one node written per edge
  a_wen_onehot : assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(node_wen)
  );

  // counter stays inside the node range
  a_addr_range : assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_addr <= LAST_ADDR
  );

endmodule : node_loader

`default_nettype wire

//--- logic/kd_tree_pkg.sv
// ====================================================================
// tree shape and word layouts are fixed here; every block depends on
// them, so changing depth or widths means revisiting the node format
// ====================================================================
`default_nettype none

package kd_tree_pkg;

  // patch shape
  localparam int NUM_DIMS    = 5;
  localparam int COORD_WIDTH = 11;

  // tree shape, six levels of internal nodes
  localparam int TREE_DEPTH = 6;
  localparam int NUM_NODES  = (2 ** TREE_DEPTH) - 1;
  localparam int NUM_LEAVES = 2 ** TREE_DEPTH;

  // dimension field width inside a node
  localparam int DIM_WIDTH = 3;

  // selects no coordinate, compare value becomes zero
  localparam logic [DIM_WIDTH-1:0] INVALID_DIM = 3'd7;

  // one signed coordinate
  typedef logic signed [COORD_WIDTH-1:0] coord_t;

  // coordinate k sits at bits 11k .. 11k+10
  typedef logic [NUM_DIMS*COORD_WIDTH-1:0] patch_t;

  // low half holds the dimension, high half the median
  typedef logic [2*COORD_WIDTH-1:0] node_word_t;

  // stored split dimension
  typedef logic [DIM_WIDTH-1:0] dim_t;

  // breadth-first node address, level i pos j -> 2^i + j - 1
  typedef logic [TREE_DEPTH-1:0] node_addr_t;

  // leaf number 0..63
  typedef logic [TREE_DEPTH-1:0] leaf_idx_t;

  // last write address before the counter wraps
  localparam node_addr_t LAST_ADDR = node_addr_t'(NUM_NODES - 1);

endpackage : kd_tree_pkg

`default_nettype wire
